// File: Makefile
SIM = obj_dir/fetch_sim

sim:
	verilator --binary --assert --top-module fetch_tb -f all.f -o fetch_sim
	out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: all.f
logic/fetch_pkg.sv
logic/fetch.sv
logic/icache.sv
logic/axil_fill_master.sv
logic/fetch_top.sv
verification/fetch_assert.sv
verification/fetch_tb.sv

// File: logic/axil_fill_master.sv
// AXI4-Lite read master issuing one single-beat read per fill request pulse
`default_nettype none

module axil_fill_master (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire fetch_pkg::fill_req_t fill_req,
    output fetch_pkg::fill_rsp_t      fill_rsp,
    output fetch_pkg::axil_ar_t       m_ar,
    output logic                      m_arvalid,
    input  wire logic                 m_arready,
    input  wire fetch_pkg::axil_r_t   m_r,
    input  wire logic                 m_rvalid,
    output logic                      m_rready
);

    localparam logic [1:0] RESP_OKAY = 2'b00;
    // Instruction, secure, unprivileged
    localparam logic [2:0] PROT_INSTR = 3'b100;

    typedef enum logic [1:0] {
        M_IDLE,
        M_ADDR,
        M_DATA
    } state_t;

    state_t      state;
    logic [31:0] araddr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= M_IDLE;
        end else begin
            case (state)
                M_IDLE:  if (fill_req.start) state <= M_ADDR;
                M_ADDR:  if (m_arready) state <= M_DATA;
                M_DATA:  if (m_rvalid) state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
        end
    end

    // Address held stable for the whole AR phase
    always_ff @(posedge clk) begin
        if (state == M_IDLE && fill_req.start) begin
            araddr_q <= fill_req.addr;
        end
    end

    assign m_arvalid   = (state == M_ADDR);
    assign m_rready    = (state == M_DATA);
    assign m_ar.araddr = araddr_q;
    assign m_ar.arprot = PROT_INSTR;

    // One beat per completed R handshake
    always_comb begin
        fill_rsp.valid = (state == M_DATA) & m_rvalid;
        fill_rsp.data  = m_r.rdata;
        fill_rsp.err   = (m_r.rresp != RESP_OKAY);
    end

endmodule

`default_nettype wire

// File: logic/fetch.sv
// Fetch control: PC register, next-PC select, redirect tracking, NOP insertion and HALT decode
`default_nettype none

module fetch #(
    parameter fetch_pkg::addr_t RESET_PC = 16'h0000
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire fetch_pkg::addr_t     new_pc,
    input  wire logic                 take_new_pc,
    input  wire logic                 stall,
    input  wire fetch_pkg::cache_rsp_t rsp,
    output fetch_pkg::cache_req_t     req,
    output fetch_pkg::fetch_out_t     out
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t pc_inc;
    fetch_pkg::addr_t nxt_pc;

    // Redirect seen while the cache was filling a stale line
    logic took_new_pc;
    logic halted_q;

    logic insert_nop;
    logic halt_dec;
    logic update_pc;

    // 16-bit instructions, so the sequential PC steps by two
    assign pc_inc = pc_q + 16'd2;
    assign nxt_pc = take_new_pc ? new_pc : pc_inc;

    // No usable word unless the cache completed a read that was not redirected
    assign insert_nop = take_new_pc | took_new_pc | ~rsp.done;

    // HALT is decoded here for immediate feedback
    assign halt_dec = rsp.done & ~take_new_pc & ~took_new_pc
                      & (rsp.data[15:11] == fetch_pkg::OP_HALT);

    // A redirect always wins; otherwise advance on a clean word when decode can take it
    assign update_pc = take_new_pc
                       | (rsp.done & ~stall & ~took_new_pc & ~halt_dec);

    // Pipelined request: ask for the next PC when the PC moves this cycle,
    // else repeat the current PC (decode stall, pending redirect, idle cache)
    always_comb begin
        req.addr = update_pc ? nxt_pc : pc_q;
        req.rd   = take_new_pc | ~(halt_dec | halted_q);
    end

    always_comb begin
        if (insert_nop) begin
            // Keep the low bits, only the opcode field is forced
            out.instr = {fetch_pkg::OP_NOP, rsp.data[10:0]};
        end else begin
            out.instr = rsp.data;
        end
        out.pc_inc = pc_inc;
        out.halt   = halt_dec | (halted_q & ~take_new_pc);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (update_pc) begin
            pc_q <= nxt_pc;
        end
    end

    // Set when a redirect lands during a fill, cleared by the fill's done
    always_ff @(posedge clk) begin
        if (rst) begin
            took_new_pc <= 1'b0;
        end else if (take_new_pc | rsp.done) begin
            took_new_pc <= take_new_pc & rsp.stall;
        end
    end

    // Halted until the next redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            halted_q <= 1'b0;
        end else if (take_new_pc) begin
            halted_q <= 1'b0;
        end else if (halt_dec) begin
            halted_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_pkg.sv
// Shared widths, opcodes and bus structs for the fetch stage, instruction cache and fill master
`default_nettype none

package fetch_pkg;

    // Byte address and 16-bit instruction word
    typedef logic [15:0] addr_t;
    typedef logic [15:0] instr_t;

    // Opcodes live in instr[15:11]
    localparam logic [4:0] OP_HALT = 5'b00000;
    localparam logic [4:0] OP_NOP  = 5'b00001;

    // Fetch to cache
    typedef struct packed {
        logic  rd;
        addr_t addr;
    } cache_req_t;

    // Cache to fetch
    typedef struct packed {
        instr_t data;
        logic   done;   // data valid this cycle
        logic   stall;  // line fill in progress
        logic   hit;
        logic   err;
    } cache_rsp_t;

    // Cache to fill master, one pulse per beat
    typedef struct packed {
        logic        start;
        logic [31:0] addr;
    } fill_req_t;

    // Fill master to cache
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        err;
    } fill_rsp_t;

    // AXI4-Lite read address and read data payloads
    typedef struct packed {
        logic [31:0] araddr;
        logic [2:0]  arprot;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_r_t;

    // Stage output towards decode
    typedef struct packed {
        instr_t instr;
        addr_t  pc_inc;
        logic   halt;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: logic/fetch_top.sv
// Fetch stage top: fetch control, instruction cache and AXI4-Lite fill master
`default_nettype none

module fetch_top #(
    parameter int               SETS       = 16,
    parameter int               LINE_BEATS = 2,
    parameter fetch_pkg::addr_t RESET_PC   = 16'h0000
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire fetch_pkg::addr_t    new_pc,
    input  wire logic                take_new_pc,
    input  wire logic                stall,
    output fetch_pkg::fetch_out_t    out,
    output logic                     err,
    output fetch_pkg::axil_ar_t      m_ar,
    output logic                     m_arvalid,
    input  wire logic                m_arready,
    input  wire fetch_pkg::axil_r_t  m_r,
    input  wire logic                m_rvalid,
    output logic                     m_rready
);

    fetch_pkg::cache_req_t cache_req;
    fetch_pkg::cache_rsp_t cache_rsp;
    fetch_pkg::fill_req_t  fill_req;
    fetch_pkg::fill_rsp_t  fill_rsp;

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .new_pc      (new_pc),
        .take_new_pc (take_new_pc),
        .stall       (stall),
        .rsp         (cache_rsp),
        .req         (cache_req),
        .out         (out)
    );

    icache #(
        .SETS       (SETS),
        .LINE_BEATS (LINE_BEATS)
    ) u_icache (
        .clk      (clk),
        .rst      (rst),
        .req      (cache_req),
        .rsp      (cache_rsp),
        .fill_req (fill_req),
        .fill_rsp (fill_rsp)
    );

    axil_fill_master u_fill (
        .clk       (clk),
        .rst       (rst),
        .fill_req  (fill_req),
        .fill_rsp  (fill_rsp),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    // Memory error reported by the cache
    assign err = cache_rsp.err;

endmodule

`default_nettype wire

// File: logic/icache.sv
// Direct-mapped instruction cache with tag, valid and data arrays and a line fill FSM
`default_nettype none

module icache #(
    parameter int SETS       = 16,
    parameter int LINE_BEATS = 2
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire fetch_pkg::cache_req_t req,
    output fetch_pkg::cache_rsp_t      rsp,
    output fetch_pkg::fill_req_t       fill_req,
    input  wire fetch_pkg::fill_rsp_t  fill_rsp
);

    // Address split: tag | index | beat | half | byte
    localparam int BEAT_W = $clog2(LINE_BEATS);
    localparam int WORD_W = BEAT_W + 1;
    localparam int IDX_W  = $clog2(SETS);
    localparam int OFF_W  = WORD_W + 1;
    localparam int TAG_W  = 16 - OFF_W - IDX_W;

    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(LINE_BEATS - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_RESP
    } state_t;

    state_t state;

    logic [TAG_W-1:0]    tag_arr  [SETS];
    fetch_pkg::instr_t   data_arr [SETS][2*LINE_BEATS];
    logic [SETS-1:0]     valid_arr;

    // Registered request, looked up one cycle later
    fetch_pkg::addr_t    addr_q;
    logic                rd_q;

    logic [IDX_W-1:0]    idx_q;
    logic [TAG_W-1:0]    tag_q;
    logic [WORD_W-1:0]   word_q;

    logic [BEAT_W-1:0]   beat_q;
    logic                start_q;
    logic                line_err_q;
    logic                err_q;

    logic                lookup_hit;
    logic                miss;
    logic                last_beat;

    assign idx_q  = addr_q[OFF_W +: IDX_W];
    assign tag_q  = addr_q[15 -: TAG_W];
    assign word_q = addr_q[OFF_W-1:1];

    assign lookup_hit = (state == S_IDLE) & rd_q & valid_arr[idx_q]
                        & (tag_arr[idx_q] == tag_q);
    assign miss       = (state == S_IDLE) & rd_q & ~lookup_hit;
    assign last_beat  = fill_rsp.valid & (beat_q == LAST_BEAT);

    always_comb begin
        rsp.data  = data_arr[idx_q][word_q];
        rsp.hit   = lookup_hit;
        rsp.done  = lookup_hit | (state == S_RESP);
        rsp.stall = miss | (state == S_FILL);
        rsp.err   = err_q;
    end

    // Word-aligned beat address within the missing line
    always_comb begin
        fill_req.start = start_q;
        fill_req.addr  = {16'h0000, addr_q[15:OFF_W], beat_q, 2'b00};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            rd_q       <= 1'b0;
            beat_q     <= '0;
            start_q    <= 1'b0;
            line_err_q <= 1'b0;
            err_q      <= 1'b0;
            valid_arr  <= '0;
        end else begin
            start_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (miss) begin
                        state              <= S_FILL;
                        beat_q             <= '0;
                        start_q            <= 1'b1;
                        line_err_q         <= 1'b0;
                        valid_arr[idx_q]   <= 1'b0;
                    end else begin
                        rd_q <= req.rd;
                    end
                end
                S_FILL: begin
                    if (fill_rsp.valid) begin
                        if (fill_rsp.err) begin
                            line_err_q <= 1'b1;
                            // Sticky until reset
                            err_q      <= 1'b1;
                        end
                        if (last_beat) begin
                            state            <= S_RESP;
                            valid_arr[idx_q] <= ~(line_err_q | fill_rsp.err);
                        end else begin
                            beat_q  <= beat_q + 1'b1;
                            start_q <= 1'b1;
                        end
                    end
                end
                S_RESP: begin
                    state <= S_IDLE;
                    rd_q  <= req.rd;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Arrays and request address
    always_ff @(posedge clk) begin
        if ((state == S_IDLE && !miss) || state == S_RESP) begin
            addr_q <= req.addr;
        end
        if (miss) begin
            tag_arr[idx_q] <= tag_q;
        end
        // Low half is the lower address
        if (state == S_FILL && fill_rsp.valid) begin
            data_arr[idx_q][{beat_q, 1'b0}] <= fill_rsp.data[15:0];
            data_arr[idx_q][{beat_q, 1'b1}] <= fill_rsp.data[31:16];
        end
    end

endmodule

`default_nettype wire

// File: verification/fetch_assert.sv
// Concurrent assertions on fetch_top AR handshake, reset state and redirect NOP insertion
`default_nettype none

module fetch_assert (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  take_new_pc,
    input wire fetch_pkg::fetch_out_t out,
    input wire fetch_pkg::axil_ar_t   m_ar,
    input wire logic                  m_arvalid,
    input wire logic                  m_arready
);

    // AR payload and valid held until the slave accepts
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        (m_arvalid && !m_arready) |=> (m_arvalid && $stable(m_ar)))
        else $error("AR channel changed before arready");

    no_halt_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !out.halt)
        else $error("halt active right after reset");

    // The redirect cycle never passes a cache word
    nop_on_redirect: assert property (@(posedge clk) disable iff (rst)
        take_new_pc |-> (out.instr[15:11] == fetch_pkg::OP_NOP))
        else $error("non-NOP word during redirect");

endmodule

bind fetch_top fetch_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .take_new_pc (take_new_pc),
    .out         (out),
    .m_ar        (m_ar),
    .m_arvalid   (m_arvalid),
    .m_arready   (m_arready)
);

`default_nettype wire

// File: verification/fetch_tb.sv
// Testbench for fetch_top with clock, reset, AXI4-Lite memory model, LFSR and directed tests
`default_nettype none

module fetch_tb;

    localparam fetch_pkg::addr_t RESET_PC = 16'h0000;

    logic                  clk;
    logic                  rst;
    fetch_pkg::addr_t      new_pc;
    logic                  take_new_pc;
    logic                  stall;
    fetch_pkg::fetch_out_t out;
    logic                  err;
    fetch_pkg::axil_ar_t   m_ar;
    logic                  m_arvalid;
    logic                  m_arready;
    fetch_pkg::axil_r_t    m_r;
    logic                  m_rvalid;
    logic                  m_rready;

    int               errors = 0;
    int               timeouts = 0;
    logic [15:0]      lfsr = 16'd66;
    fetch_pkg::addr_t exp_pc;
    fetch_pkg::addr_t halt_addr = 16'hFFFF;
    fetch_pkg::addr_t err_addr = 16'hFFFF;

    fetch_top #(
        .SETS       (16),
        .LINE_BEATS (2),
        .RESET_PC   (RESET_PC)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .new_pc      (new_pc),
        .take_new_pc (take_new_pc),
        .stall       (stall),
        .out         (out),
        .err         (err),
        .m_ar        (m_ar),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .m_r         (m_r),
        .m_rvalid    (m_rvalid),
        .m_rready    (m_rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 16'hB400;
        return n;
    endfunction

    task automatic draw_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic pick_delay(output int d);
        logic b0;
        logic b1;
        draw_bit(b0);
        draw_bit(b1);
        d = 2 * int'(b1) + int'(b0);
    endtask

    // Memory word opcode is always 1xxxx so never HALT or NOP unless placed
    function automatic fetch_pkg::instr_t model_word(input fetch_pkg::addr_t a);
        if (a == halt_addr) begin
            return {fetch_pkg::OP_HALT, a[11:1]};
        end
        return {1'b1, a[4:1] ^ a[8:5], a[11:1] ^ 11'h5a3};
    endfunction

    task automatic check_instr(input string name, input fetch_pkg::instr_t got,
                               input fetch_pkg::instr_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    // AXI4-Lite slave with one beat per AR and random ready and valid delays
    initial begin : axi_slave
        logic [15:0] addr;
        int          ar_delay;
        int          r_delay;
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_r       = '0;
        forever begin
            @(negedge clk);
            if (m_arvalid === 1'b1) begin
                addr = m_ar.araddr[15:0];
                // ARPROT bit 2 marks an instruction access
                check_bit("m_ar.arprot[2]", m_ar.arprot[2], 1'b1);
                pick_delay(ar_delay);
                pick_delay(r_delay);
                repeat (ar_delay) @(posedge clk);
                @(posedge clk);
                #1 m_arready = 1'b1;
                @(posedge clk);
                #1 m_arready = 1'b0;
                repeat (r_delay) begin
                    @(posedge clk);
                    #1;
                end
                m_r.rdata = {model_word(addr + 16'd2), model_word(addr)};
                m_r.rresp = ((err_addr & 16'hFFFC) == addr) ? 2'b10 : 2'b00;
                m_rvalid  = 1'b1;
                @(negedge clk);
                check_bit("m_rready", m_rready, 1'b1);
                @(posedge clk);
                #1 m_rvalid = 1'b0;
            end
        end
    end

    // Redirect cycle that leaves take_new_pc high until the caller's next drive step
    task automatic redirect(input fetch_pkg::addr_t target);
        @(posedge clk);
        #1;
        stall       = 1'b0;
        take_new_pc = 1'b1;
        new_pc      = target;
        @(negedge clk);
        check_bit("nop_on_redirect", out.instr[15:11] == fetch_pkg::OP_NOP, 1'b1);
        exp_pc = target;
    endtask

    // Collect n words in order and skip NOPs and words seen under stall
    task automatic run_words(input int n, input logic rand_stall, input logic back_to_back);
        int   got;
        int   cycles;
        logic b;
        logic started;
        got     = 0;
        cycles  = 0;
        started = 1'b0;
        while (got < n && cycles < n * 60 + 200) begin
            @(posedge clk);
            #1;
            take_new_pc = 1'b0;
            b = 1'b0;
            if (rand_stall) draw_bit(b);
            stall = b;
            @(negedge clk);
            cycles++;
            if (out.instr[15:11] != fetch_pkg::OP_NOP && !stall) begin
                check_instr("out.instr", out.instr, model_word(exp_pc));
                check_addr("out.pc_inc", out.pc_inc, exp_pc + 16'd2);
                exp_pc  = exp_pc + 16'd2;
                got++;
                started = 1'b1;
            end else if (back_to_back && started) begin
                errors++;
                $display("Hit sequence has a gap before address %h", exp_pc);
            end
        end
        if (got < n) begin
            timeouts++;
            $display("Timed out waiting for words at address %h", exp_pc);
        end
    endtask

    task automatic sequential_fetch();
        exp_pc = RESET_PC;
        run_words(16, 1'b0, 1'b0);
        check_bit("err", err, 1'b0);
    endtask

    task automatic hits_after_refill();
        redirect(RESET_PC);
        run_words(16, 1'b0, 1'b1);
    endtask

    task automatic fill_then_redirect();
        int cycles;
        redirect(16'h0200);
        cycles = 0;
        while (cycles < 100) begin
            @(posedge clk);
            #1 take_new_pc = 1'b0;
            @(negedge clk);
            cycles++;
            if (m_arvalid) break;
        end
        if (!m_arvalid) begin
            timeouts++;
            $display("Timed out waiting for a line fill to start");
        end
        redirect(16'h0300);
        run_words(8, 1'b0, 1'b0);
    endtask

    task automatic decode_stall();
        redirect(16'h0100);
        run_words(24, 1'b1, 1'b0);
        check_bit("err", err, 1'b0);
    endtask

    task automatic halt_until_redirect();
        int cycles;
        halt_addr = 16'h0408;
        redirect(16'h0400);
        run_words(4, 1'b0, 1'b0);
        cycles = 0;
        while (cycles < 200 && !out.halt) begin
            @(posedge clk);
            #1 take_new_pc = 1'b0;
            @(negedge clk);
            cycles++;
        end
        if (!out.halt) begin
            timeouts++;
            $display("Timed out waiting for halt");
        end else begin
            check_instr("out.instr", out.instr, model_word(exp_pc));
            check_addr("out.pc_inc", out.pc_inc, exp_pc + 16'd2);
        end
        repeat (20) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("out.halt", out.halt, 1'b1);
            check_bit("new_word_while_halted", out.instr[15:11] != fetch_pkg::OP_NOP, 1'b0);
        end
        redirect(RESET_PC);
        check_bit("out.halt", out.halt, 1'b0);
        run_words(4, 1'b0, 1'b0);
    endtask

    task automatic memory_error();
        int cycles;
        err_addr = 16'h0602;
        redirect(16'h0600);
        cycles = 0;
        while (cycles < 300 && !err) begin
            @(posedge clk);
            #1 take_new_pc = 1'b0;
            @(negedge clk);
            cycles++;
        end
        if (!err) begin
            timeouts++;
            $display("Timed out waiting for the memory error flag");
        end
        check_bit("err", err, 1'b1);
    endtask

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        take_new_pc = 1'b0;
        new_pc      = '0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_bit("out.halt", out.halt, 1'b0);
        sequential_fetch();
        hits_after_refill();
        fill_then_redirect();
        decode_stall();
        halt_until_redirect();
        memory_error();
        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
